// ==== verilog.f ====
src/isp_pkg.sv
src/isp_regs.sv
src/black_level.sv
src/rgb_gain.sv
src/frame_stats.sv
src/raw_isp_top.sv
dv/raw_isp_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the raw ISP testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module raw_isp_tb -o raw_isp_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/raw_isp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

// ==== dv/raw_isp_tb.sv ====
`timescale 1ns/100ps

module raw_isp_tb;

	localparam int P_DEPTH     = 10;
	localparam int STAT_W      = 32;
	localparam int LANES       = isp_pkg::LANES;
	localparam int PW          = LANES*P_DEPTH;
	localparam int NFRAMES     = 8;
	localparam int LINES       = 6;
	localparam int BEATS       = 8;
	localparam int VB_MAX      = 8;
	localparam int IDLE        = 8; // beats after vs falls, sums land within these
	localparam int CLK_NS      = 4;
	localparam int FRAME_MAX   = VB_MAX + IDLE + LINES*(2*BEATS + 2);
	localparam int WATCHDOG_NS = (8 + (NFRAMES + 1)*FRAME_MAX + 100)*CLK_NS;

	typedef logic [P_DEPTH-1:0] pix_t;
	typedef logic [STAT_W-1:0] sum_t;

	// expected output of one beat, two cycles after it was driven
	typedef struct packed
	{
		isp_pkg::sync_t sync;
		logic [PW-1:0]  data;
		logic [PW-1:0]  raw;
		logic           passthru;
		logic [2:0]     test;
	} beat_t;

	logic               i_pclk;
	logic               i_arstn;
	isp_pkg::sync_t     i_sync;
	logic [PW-1:0]      i_data;
	logic               i_reg_wr;
	isp_pkg::reg_addr_t i_reg_addr;
	isp_pkg::reg_data_t i_reg_wdata;
	isp_pkg::sync_t     o_sync;
	logic [PW-1:0]      o_data;
	isp_pkg::reg_data_t o_reg_rdata;

	isp_pkg::gains_t act_gains;
	isp_pkg::gains_t stg_gains;
	pix_t            act_black;
	pix_t            stg_black;
	sum_t            acc [3]; // red, green, blue
	sum_t            done_sum [3];
	logic            prev_vs;
	beat_t           pipe [$];
	int              errors [1:5];
	int              checks;

	raw_isp_top #(.P_DEPTH(P_DEPTH), .STAT_W(STAT_W)) u_dut (
		.i_pclk(i_pclk), .i_arstn(i_arstn), .i_sync(i_sync), .i_data(i_data),
		.i_reg_wr(i_reg_wr), .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata),
		.o_sync(o_sync), .o_data(o_data), .o_reg_rdata(o_reg_rdata)
	);

	initial
	begin
		i_pclk = 1'b0;
		forever #(CLK_NS/2) i_pclk = ~i_pclk;
	end

	// shift-and-add white balance with clamping to the pixel range
	function automatic pix_t apply_gain(input pix_t x, input logic [2:0] code);
		int xi;
		int v;
		xi = int'(x);
		if (code[2])
			v = xi + (code[1] ? xi/2 : 0) + (code[0] ? xi/4 : 0);
		else
			v = xi - xi/4 - (code[1] ? 0 : xi/2) - (code[0] ? 0 : xi/4);
		if (v < 0)
			v = 0;
		if (v >= (1 << P_DEPTH))
			v = (1 << P_DEPTH) - 1;
		return pix_t'(v);
	endfunction

	function automatic int lane_colour(input int lane, input int line);
		if (line % 2 == 0)
			return (lane % 2 == 1) ? 0 : 1; // R Gr
		else
			return (lane % 2 == 1) ? 1 : 2; // Gb B
	endfunction

	function automatic logic [2:0] colour_code(input int c);
		case (c)
			0:       return act_gains.red;
			1:       return act_gains.green;
			default: return act_gains.blue;
		endcase
	endfunction

	function automatic logic [PW-1:0] rand_data();
		logic [PW-1:0] d;
		for (int l = 0; l < LANES; l++)
			d[l*P_DEPTH +: P_DEPTH] = pix_t'($urandom);
		return d;
	endfunction

	task automatic report(input int t, input string what, input logic [63:0] got,
		input logic [63:0] want);
		errors[t]++;
		$display("error %0t ns: test %0d %s, got %0h expected %0h", $time, t, what, got, want);
	endtask

	task automatic print_test(input int t, input string name);
		$display("test %0d %s: %s (%0d errors)", t, name, (errors[t] == 0) ? "ok" : "failed",
			errors[t]);
	endtask

	task automatic read_check(input int t, input isp_pkg::reg_addr_t a,
		input isp_pkg::reg_data_t want, input string what);
		i_reg_addr = a;
		#0.3;
		if (o_reg_rdata !== want)
			report(t, what, 64'(o_reg_rdata), 64'(want));
	endtask

	task automatic stage_write(input isp_pkg::reg_addr_t a, input isp_pkg::reg_data_t d);
		i_reg_wr    = 1'b1;
		i_reg_addr  = a;
		i_reg_wdata = d;
		if (a == isp_pkg::ADDR_GAINS)
			stg_gains = isp_pkg::gains_t'(d[8:0]);
		else if (a == isp_pkg::ADDR_BLACK)
			stg_black = d[P_DEPTH-1:0];
	endtask

	task automatic check_output();
		beat_t want;
		want = pipe.pop_front();
		checks++;
		if (o_sync !== want.sync)
			report(int'(want.test), "o_sync", 64'(o_sync), 64'(want.sync));
		if (o_data !== want.data)
			report(int'(want.test), "o_data", 64'(o_data), 64'(want.data));
		if (want.passthru && o_data !== want.raw)
			report(int'(want.test), "o_data against delayed i_data", 64'(o_data), 64'(want.raw));
	endtask

	task automatic drive_beat(input isp_pkg::sync_t s, input logic [PW-1:0] d, input int line,
		input int t);
		beat_t want;
		pix_t  px;
		pix_t  gained;
		int    v;
		int    c;
		@(negedge i_pclk);
		check_output();
		want.sync     = s;
		want.raw      = d;
		want.data     = '0;
		want.passthru = (act_gains == 9'h124) && (act_black == '0);
		want.test     = 3'(t);
		for (int l = 0; l < LANES; l++)
		begin
			px = d[l*P_DEPTH +: P_DEPTH];
			v = int'(px) - int'(act_black);
			if (v < 0)
				v = 0;
			c = lane_colour(l, line);
			gained = apply_gain(pix_t'(v), colour_code(c));
			want.data[l*P_DEPTH +: P_DEPTH] = gained;
			if (s.de && s.valid)
				acc[c] = acc[c] + sum_t'(gained);
		end
		if (prev_vs && !s.vs) // frame boundary closes the sums and loads staged settings
		begin
			for (int k = 0; k < 3; k++)
			begin
				done_sum[k] = acc[k];
				acc[k] = '0;
			end
			act_gains = stg_gains;
			act_black = stg_black;
		end
		prev_vs = s.vs;
		pipe.push_back(want);
		i_sync   = s;
		i_data   = d;
		i_reg_wr = 1'b0;
	endtask

	task automatic run_frame(input int f);
		isp_pkg::sync_t  s;
		isp_pkg::gains_t prev_gains;
		pix_t            prev_black;
		int              vb;
		int              tail;
		int              t;
		logic            changed;
		vb   = 3 + int'($urandom % 5);
		tail = (f == 0) ? 1 : ((f == 1) ? 2 : 3); // vblank still flushes the previous frame
		s    = '0;
		s.vs = 1'b1;
		for (int i = 0; i < vb; i++)
		begin
			drive_beat(s, '0, 0, tail);
			if (f > 0 && f < NFRAMES && i == 0 && (f == 1 || $urandom % 4 != 0))
				stage_write(isp_pkg::ADDR_GAINS, $urandom % 512);
			else if (f > 0 && f < NFRAMES && i == 1 && $urandom % 2 == 0)
				stage_write(isp_pkg::ADDR_BLACK, $urandom % 200);
			else if (i == vb - 1)
			begin
				read_check(4, isp_pkg::ADDR_GAINS, 32'(act_gains), "gains before frame start");
				read_check(4, isp_pkg::ADDR_BLACK, 32'(act_black), "black before frame start");
			end
		end
		prev_gains = act_gains;
		prev_black = act_black;
		s.vs = 1'b0;
		drive_beat(s, '0, 0, tail);
		changed = (act_gains != prev_gains) || (act_black != prev_black);
		for (int j = 1; j < IDLE; j++)
		begin
			drive_beat(s, '0, 0, tail);
			if (j == 4) // 2 cycles after o_sync.vs fell
			begin
				read_check(5, isp_pkg::ADDR_SUM_R, 32'(done_sum[0]), "red sum");
				read_check(5, isp_pkg::ADDR_SUM_G, 32'(done_sum[1]), "green sum");
				read_check(5, isp_pkg::ADDR_SUM_B, 32'(done_sum[2]), "blue sum");
				read_check(4, isp_pkg::ADDR_GAINS, 32'(act_gains), "gains at frame start");
				read_check(4, isp_pkg::ADDR_BLACK, 32'(act_black), "black at frame start");
			end
		end
		if (f < NFRAMES)
		begin
			for (int ln = 0; ln < LINES; ln++)
			begin
				t = (f == 0) ? 2 : ((changed && ln == 0) ? 4 : 3);
				s = '0;
				s.hs = 1'b1;
				drive_beat(s, '0, ln, t);
				s.hs = 1'b0;
				s.de = 1'b1;
				for (int bt = 0; bt < BEATS; bt++)
				begin
					if ($urandom % 4 == 0)
					begin
						s.valid = 1'b0;
						drive_beat(s, rand_data(), ln, t); // valid gap inside the line
					end
					s.valid = 1'b1;
					drive_beat(s, rand_data(), ln, t);
				end
				s = '0;
				drive_beat(s, '0, ln, t);
			end
		end
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		beat_t z;
		int    total;
		void'($urandom(84));
		i_arstn     = 1'b0;
		i_sync      = '0;
		i_data      = '0;
		i_reg_wr    = 1'b0;
		i_reg_addr  = '0;
		i_reg_wdata = '0;
		act_gains   = 9'h124;
		stg_gains   = 9'h124;
		act_black   = '0;
		stg_black   = '0;
		prev_vs     = 1'b0;
		checks      = 0;
		for (int k = 0; k < 3; k++)
		begin
			acc[k]      = '0;
			done_sum[k] = '0;
		end
		for (int t = 1; t <= 5; t++)
			errors[t] = 0;
		z      = '0;
		z.test = 3'd1;
		pipe.push_back(z); // outputs stay zero out of reset
		pipe.push_back(z);
		repeat (8) @(posedge i_pclk);
		@(negedge i_pclk);
		i_arstn = 1'b1;
		#0.3;
		if (o_sync !== '0)
			report(1, "o_sync after reset", 64'(o_sync), 64'(0));
		if (o_data !== '0)
			report(1, "o_data after reset", 64'(o_data), 64'(0));
		read_check(1, isp_pkg::ADDR_GAINS, 32'h124, "gains after reset");
		read_check(1, isp_pkg::ADDR_BLACK, 32'h0, "black after reset");
		read_check(1, isp_pkg::ADDR_SUM_R, 32'h0, "red sum after reset");
		read_check(1, isp_pkg::ADDR_SUM_G, 32'h0, "green sum after reset");
		read_check(1, isp_pkg::ADDR_SUM_B, 32'h0, "blue sum after reset");
		read_check(1, 3'd5, 32'h0, "unused address");
		run_frame(0);
		print_test(1, "reset values");
		run_frame(1);
		print_test(2, "unity pass-through");
		for (int f = 2; f <= NFRAMES; f++)
			run_frame(f);
		print_test(3, "random black level and gains");
		print_test(4, "gain update at frame start");
		print_test(5, "frame sums");
		total = 0;
		for (int t = 1; t <= 5; t++)
			total += errors[t];
		$display("done: %0d beat checks, %0d errors", checks, total);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== src/raw_isp_top.sv ====
`timescale 1ns/100ps

module raw_isp_top
#(
	parameter int P_DEPTH = 10,
	parameter int STAT_W  = 32
)
(
	input  logic                                i_pclk,
	input  logic                                i_arstn,
	input  isp_pkg::sync_t                      i_sync,
	input  logic [isp_pkg::LANES*P_DEPTH-1:0]   i_data,
	input  logic                                i_reg_wr,
	input  isp_pkg::reg_addr_t                  i_reg_addr,
	input  isp_pkg::reg_data_t                  i_reg_wdata,
	output isp_pkg::sync_t                      o_sync,
	output logic [isp_pkg::LANES*P_DEPTH-1:0]   o_data,
	output isp_pkg::reg_data_t                  o_reg_rdata
);

	isp_pkg::sync_t                      bl_sync;
	logic [isp_pkg::LANES*P_DEPTH-1:0]   bl_data;
	isp_pkg::sync_t                      gn_sync;
	logic [isp_pkg::LANES*P_DEPTH-1:0]   gn_data;
	isp_pkg::gains_t                     gains;
	logic [P_DEPTH-1:0]                  black;
	logic                                stat_done;
	logic [STAT_W-1:0]                   sum_r;
	logic [STAT_W-1:0]                   sum_g;
	logic [STAT_W-1:0]                   sum_b;

	isp_regs #(.P_DEPTH(P_DEPTH), .STAT_W(STAT_W)) u_regs (
		.i_pclk(i_pclk), .i_arstn(i_arstn),
		.i_reg_wr(i_reg_wr), .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata),
		.i_frame_vs(i_sync.vs), // staged settings apply at input frame start
		.i_stat_done(stat_done), .i_sum_r(sum_r), .i_sum_g(sum_g), .i_sum_b(sum_b),
		.o_reg_rdata(o_reg_rdata), .o_gains(gains), .o_black(black)
	);

	black_level #(.P_DEPTH(P_DEPTH)) u_black (
		.i_pclk(i_pclk), .i_arstn(i_arstn), .i_sync(i_sync), .i_data(i_data),
		.i_black(black), .o_sync(bl_sync), .o_data(bl_data)
	);

	rgb_gain #(.P_DEPTH(P_DEPTH)) u_gain (
		.i_pclk(i_pclk), .i_arstn(i_arstn), .i_sync(bl_sync), .i_data(bl_data),
		.i_gains(gains), .o_sync(gn_sync), .o_data(gn_data)
	);

	frame_stats #(.P_DEPTH(P_DEPTH), .STAT_W(STAT_W)) u_stats (
		.i_pclk(i_pclk), .i_arstn(i_arstn), .i_sync(gn_sync), .i_data(gn_data),
		.o_stat_done(stat_done), .o_sum_r(sum_r), .o_sum_g(sum_g), .o_sum_b(sum_b)
	);

	assign o_sync = gn_sync;
	assign o_data = gn_data;

endmodule

// ==== src/frame_stats.sv ====
`timescale 1ns/100ps

module frame_stats
#(
	parameter int P_DEPTH = 10,
	parameter int STAT_W  = 32
)
(
	input  logic                                i_pclk,
	input  logic                                i_arstn,
	input  isp_pkg::sync_t                      i_sync,
	input  logic [isp_pkg::LANES*P_DEPTH-1:0]   i_data,
	output logic                                o_stat_done,
	output logic [STAT_W-1:0]                   o_sum_r,
	output logic [STAT_W-1:0]                   o_sum_g,
	output logic [STAT_W-1:0]                   o_sum_b
);

	typedef logic [STAT_W-1:0] sum_t;

	logic r_vs_d;
	logic r_de_d;
	logic r_parity;
	logic w_beat;
	logic w_frame_end;
	sum_t w_odd_lanes;
	sum_t w_even_lanes;
	sum_t w_next_r;
	sum_t w_next_g;
	sum_t w_next_b;
	sum_t r_acc_r;
	sum_t r_acc_g;
	sum_t r_acc_b;
	sum_t r_sum_r;
	sum_t r_sum_g;
	sum_t r_sum_b;
	logic r_done;

	assign w_beat      = i_sync.de && i_sync.valid;
	assign w_frame_end = r_vs_d && !i_sync.vs;

	always_comb
	begin
		w_odd_lanes  = '0;
		w_even_lanes = '0;
		for (int l = 0; l < isp_pkg::LANES; l++)
		begin
			if (l[0])
				w_odd_lanes = w_odd_lanes + sum_t'(i_data[l*P_DEPTH +: P_DEPTH]);
			else
				w_even_lanes = w_even_lanes + sum_t'(i_data[l*P_DEPTH +: P_DEPTH]);
		end
		// odd lanes carry R or Gb, even lanes Gr or B
		w_next_r = r_acc_r + ((w_beat && !r_parity) ? w_odd_lanes : '0);
		w_next_g = r_acc_g + (!w_beat ? '0 : (r_parity ? w_odd_lanes : w_even_lanes));
		w_next_b = r_acc_b + ((w_beat && r_parity) ? w_even_lanes : '0);
	end

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_vs_d   <= 1'b0;
			r_de_d   <= 1'b0;
			r_parity <= 1'b0;
			r_acc_r  <= '0;
			r_acc_g  <= '0;
			r_acc_b  <= '0;
			r_sum_r  <= '0;
			r_sum_g  <= '0;
			r_sum_b  <= '0;
			r_done   <= 1'b0;
		end
		else
		begin
			r_vs_d <= i_sync.vs;
			r_de_d <= i_sync.de;
			r_done <= w_frame_end;
			if (w_frame_end)
			begin
				r_parity <= 1'b0;
				r_sum_r  <= w_next_r;
				r_sum_g  <= w_next_g;
				r_sum_b  <= w_next_b;
				r_acc_r  <= '0;
				r_acc_g  <= '0;
				r_acc_b  <= '0;
			end
			else
			begin
				if (r_de_d && !i_sync.de)
					r_parity <= ~r_parity;
				r_acc_r <= w_next_r; // wraps at STAT_W
				r_acc_g <= w_next_g;
				r_acc_b <= w_next_b;
			end
		end
	end

	assign o_stat_done = r_done;
	assign o_sum_r     = r_sum_r;
	assign o_sum_g     = r_sum_g;
	assign o_sum_b     = r_sum_b;

endmodule

// ==== src/rgb_gain.sv ====
`timescale 1ns/100ps

module rgb_gain
#(
	parameter int P_DEPTH = 10
)
(
	input  logic                                i_pclk,
	input  logic                                i_arstn,
	input  isp_pkg::sync_t                      i_sync,
	input  logic [isp_pkg::LANES*P_DEPTH-1:0]   i_data,
	input  isp_pkg::gains_t                     i_gains,
	output isp_pkg::sync_t                      o_sync,
	output logic [isp_pkg::LANES*P_DEPTH-1:0]   o_data
);

	localparam int PW = isp_pkg::LANES*P_DEPTH;
	localparam int W  = P_DEPTH + 2; // sign plus one overflow bit

	typedef logic [P_DEPTH-1:0] pix_t;
	typedef logic signed [W-1:0] wide_t;

	function automatic wide_t gain_mult(input pix_t x, input isp_pkg::gain_code_t g);
		wide_t x1;
		wide_t x2;
		wide_t x4;
		x1 = wide_t'({2'b00, x});
		x2 = wide_t'({3'b000, x[P_DEPTH-1:1]}); // x>>1 truncated
		x4 = wide_t'({4'b0000, x[P_DEPTH-1:2]}); // x>>2 truncated
		if (g[2])
			gain_mult = x1 + (g[1] ? x2 : wide_t'(0)) + (g[0] ? x4 : wide_t'(0));
		else
			gain_mult = x1 - x4 - (g[1] ? wide_t'(0) : x2) - (g[0] ? wide_t'(0) : x4);
	endfunction

	function automatic pix_t clamp_pix(input wide_t v);
		if (v[W-1])
			clamp_pix = '0;
		else if (v[P_DEPTH])
			clamp_pix = '1; // saturate at full scale
		else
			clamp_pix = v[P_DEPTH-1:0];
	endfunction

	// R Gr R Gr on even lines, Gb B Gb B on odd lines
	function automatic isp_pkg::gain_code_t lane_code(input logic odd_lane, input logic odd_line,
		input isp_pkg::gains_t g);
		if (!odd_line)
			lane_code = odd_lane ? g.red : g.green;
		else
			lane_code = odd_lane ? g.green : g.blue;
	endfunction

	logic           r_vs_d;
	logic           r_de_d;
	logic           r_parity;
	logic           r_wait_first;
	wide_t          w_gained [isp_pkg::LANES];
	logic [PW-1:0]  w_data;
	isp_pkg::sync_t r_sync;
	logic [PW-1:0]  r_data;

	always_comb
	begin
		for (int l = 0; l < isp_pkg::LANES; l++)
		begin
			w_gained[l] = gain_mult(i_data[l*P_DEPTH +: P_DEPTH], lane_code(l[0], r_parity, i_gains));
			w_data[l*P_DEPTH +: P_DEPTH] = clamp_pix(w_gained[l]);
		end
	end

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_vs_d       <= 1'b0;
			r_de_d       <= 1'b0;
			r_parity     <= 1'b0;
			r_wait_first <= 1'b0;
			r_sync       <= '0;
			r_data       <= '0;
		end
		else
		begin
			r_vs_d <= i_sync.vs;
			r_de_d <= i_sync.de;
			r_sync <= i_sync;
			r_data <= w_data;
			if (r_vs_d && !i_sync.vs) // new frame starts on an even line
			begin
				r_parity     <= 1'b0;
				r_wait_first <= 1'b1;
			end
			else
			begin
				if (r_de_d && !i_sync.de)
					r_parity <= ~r_parity; // end of line
				if (i_sync.de)
					r_wait_first <= 1'b0;
			end
		end
	end

	assign o_sync = r_sync;
	assign o_data = r_data;

	a_first_line_even: assert property (@(posedge i_pclk) disable iff (!i_arstn)
		(r_wait_first && i_sync.de) |-> !r_parity);

	for (genvar l = 0; l < isp_pkg::LANES; l++)
	begin : g_lane_chk
		// gains of 1.0 and up never darken a lane, so overflow cannot wrap
		a_no_darken: assert property (@(posedge i_pclk) disable iff (!i_arstn)
			(lane_code(l % 2 == 1, r_parity, i_gains) >= isp_pkg::GAIN_UNITY)
			|=> (o_data[l*P_DEPTH +: P_DEPTH] >= $past(i_data[l*P_DEPTH +: P_DEPTH])));
	end

endmodule

// ==== src/black_level.sv ====
`timescale 1ns/100ps

module black_level
#(
	parameter int P_DEPTH = 10
)
(
	input  logic                                i_pclk,
	input  logic                                i_arstn,
	input  isp_pkg::sync_t                      i_sync,
	input  logic [isp_pkg::LANES*P_DEPTH-1:0]   i_data,
	input  logic [P_DEPTH-1:0]                  i_black,
	output isp_pkg::sync_t                      o_sync,
	output logic [isp_pkg::LANES*P_DEPTH-1:0]   o_data
);

	localparam int PW = isp_pkg::LANES*P_DEPTH;

	typedef logic [P_DEPTH-1:0] pix_t;

	logic [PW-1:0]  w_data;
	isp_pkg::sync_t r_sync;
	logic [PW-1:0]  r_data;

	always_comb
	begin
		for (int l = 0; l < isp_pkg::LANES; l++)
		begin
			if (pix_t'(i_data[l*P_DEPTH +: P_DEPTH]) > i_black)
				w_data[l*P_DEPTH +: P_DEPTH] = i_data[l*P_DEPTH +: P_DEPTH] - i_black;
			else
				w_data[l*P_DEPTH +: P_DEPTH] = '0; // floor at zero
		end
	end

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_sync <= '0;
			r_data <= '0;
		end
		else
		begin
			r_sync <= i_sync;
			r_data <= w_data;
		end
	end

	assign o_sync = r_sync;
	assign o_data = r_data;

endmodule

// ==== src/isp_regs.sv ====
`timescale 1ns/100ps

module isp_regs
#(
	parameter int P_DEPTH = 10,
	parameter int STAT_W  = 32
)
(
	input  logic               i_pclk,
	input  logic               i_arstn,
	input  logic               i_reg_wr,
	input  isp_pkg::reg_addr_t i_reg_addr,
	input  isp_pkg::reg_data_t i_reg_wdata,
	input  logic               i_frame_vs,
	input  logic               i_stat_done,
	input  logic [STAT_W-1:0]  i_sum_r,
	input  logic [STAT_W-1:0]  i_sum_g,
	input  logic [STAT_W-1:0]  i_sum_b,
	output isp_pkg::reg_data_t o_reg_rdata,
	output isp_pkg::gains_t    o_gains,
	output logic [P_DEPTH-1:0] o_black
);

	typedef logic [P_DEPTH-1:0] pix_t;
	typedef logic [STAT_W-1:0] sum_t;

	isp_pkg::gains_t r_gains_stg;
	isp_pkg::gains_t r_gains;
	pix_t            r_black_stg;
	pix_t            r_black;
	logic            r_vs_d;
	sum_t            r_sum_r;
	sum_t            r_sum_g;
	sum_t            r_sum_b;

	if (STAT_W > 32)
		$error("STAT_W must fit the 32-bit register word");

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_gains_stg <= isp_pkg::GAINS_RESET;
			r_gains     <= isp_pkg::GAINS_RESET;
			r_black_stg <= '0;
			r_black     <= '0;
			r_vs_d      <= 1'b0;
			r_sum_r     <= '0;
			r_sum_g     <= '0;
			r_sum_b     <= '0;
		end
		else
		begin
			r_vs_d <= i_frame_vs;
			if (i_reg_wr && i_reg_addr == isp_pkg::ADDR_GAINS)
				r_gains_stg <= isp_pkg::gains_t'(i_reg_wdata[$bits(isp_pkg::gains_t)-1:0]);
			if (i_reg_wr && i_reg_addr == isp_pkg::ADDR_BLACK)
				r_black_stg <= i_reg_wdata[P_DEPTH-1:0];
			if (r_vs_d && !i_frame_vs) // frame start, no mid-frame change
			begin
				r_gains <= r_gains_stg;
				r_black <= r_black_stg;
			end
			if (i_stat_done)
			begin
				r_sum_r <= i_sum_r;
				r_sum_g <= i_sum_g;
				r_sum_b <= i_sum_b;
			end
		end
	end

	always_comb
	begin
		case (i_reg_addr)
			isp_pkg::ADDR_GAINS: o_reg_rdata = isp_pkg::reg_data_t'(r_gains);
			isp_pkg::ADDR_BLACK: o_reg_rdata = isp_pkg::reg_data_t'(r_black);
			isp_pkg::ADDR_SUM_R: o_reg_rdata = isp_pkg::reg_data_t'(r_sum_r);
			isp_pkg::ADDR_SUM_G: o_reg_rdata = isp_pkg::reg_data_t'(r_sum_g);
			isp_pkg::ADDR_SUM_B: o_reg_rdata = isp_pkg::reg_data_t'(r_sum_b);
			default:             o_reg_rdata = '0;
		endcase
	end

	assign o_gains = r_gains;
	assign o_black = r_black;

	// frame_stats reports once per frame
	a_done_pulse: assert property (@(posedge i_pclk) disable iff (!i_arstn)
		i_stat_done |=> !i_stat_done);

endmodule

// ==== src/isp_pkg.sv ====
package isp_pkg;

	localparam int LANES = 4; // pixels per beat

	// video timing that travels beside the pixel lanes
	typedef struct packed
	{
		logic hs;
		logic vs;
		logic de;
		logic valid;
	} sync_t;

	// bit 2 set: 1.0 to 1.75, bit 2 clear: 0.0 to 0.75
	typedef logic [2:0] gain_code_t;

	typedef struct packed
	{
		gain_code_t red;
		gain_code_t green;
		gain_code_t blue;
	} gains_t;

	typedef logic [2:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;

	localparam gain_code_t GAIN_UNITY = 3'b100;

	localparam reg_addr_t ADDR_GAINS = 3'd0;
	localparam reg_addr_t ADDR_BLACK = 3'd1;
	localparam reg_addr_t ADDR_SUM_R = 3'd2;
	localparam reg_addr_t ADDR_SUM_G = 3'd3;
	localparam reg_addr_t ADDR_SUM_B = 3'd4;

	localparam gains_t GAINS_RESET = '{
		red:   GAIN_UNITY,
		green: GAIN_UNITY,
		blue:  GAIN_UNITY
	};

endpackage
